// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_exec_stage
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Finished with errors

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// data word width of the rv32 datapath
`define XLEN 32

// destination register index width, x0..x31
`define REG_ADDR_W 5

// only the low five bits of a shift operand count
`define SHAMT_W 5

// link value is the address of the next sequential instruction
`define PC_STEP 4

`define OP_W 5

`endif

// File: rtl/alu_unit.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module alu_unit (
    exec_op_if.consumer    op_if,
    output exec_pkg::xlen_t result_o
);
    import exec_pkg::*;

    // signed views for arithmetic shift and signed compare
    logic signed [`XLEN-1:0] op1_s;
    logic signed [`XLEN-1:0] op2_s;
    logic signed [`XLEN-1:0] imm_s;

    // shift amounts, upper bits ignored as rv32i requires
    logic [`SHAMT_W-1:0] shamt_reg;
    logic [`SHAMT_W-1:0] shamt_imm;

    // shared adders for address forms and pc relative values
    xlen_t addr_sum;
    xlen_t pc_rel;
    xlen_t link;

    assign op1_s = op_if.operand1;
    assign op2_s = op_if.operand2;
    assign imm_s = op_if.imm;

    assign shamt_reg = op_if.operand2[`SHAMT_W-1:0];
    assign shamt_imm = op_if.imm[`SHAMT_W-1:0];

    assign addr_sum = op_if.operand1 + op_if.imm;
    assign pc_rel   = op_if.pc + op_if.imm;
    assign link     = op_if.pc + xlen_t'(`PC_STEP);

    always_comb begin
        result_o = '0;
        unique case (op_if.op)
            // register forms
            OP_ADD:   result_o = op_if.operand1 + op_if.operand2;
            OP_SUB:   result_o = op_if.operand1 - op_if.operand2;
            OP_XOR:   result_o = op_if.operand1 ^ op_if.operand2;
            OP_OR:    result_o = op_if.operand1 | op_if.operand2;
            OP_AND:   result_o = op_if.operand1 & op_if.operand2;
            OP_SLL:   result_o = op_if.operand1 << shamt_reg;
            OP_SRL:   result_o = op_if.operand1 >> shamt_reg;
            OP_SRA:   result_o = xlen_t'(op1_s >>> shamt_reg);
            OP_SLT:   result_o = xlen_t'(op1_s < op2_s);
            OP_SLTU:  result_o = xlen_t'(op_if.operand1 < op_if.operand2);
            // immediate forms
            OP_ADDI:  result_o = addr_sum;
            OP_XORI:  result_o = op_if.operand1 ^ op_if.imm;
            OP_ORI:   result_o = op_if.operand1 | op_if.imm;
            OP_ANDI:  result_o = op_if.operand1 & op_if.imm;
            OP_SLLI:  result_o = op_if.operand1 << shamt_imm;
            OP_SRLI:  result_o = op_if.operand1 >> shamt_imm;
            OP_SRAI:  result_o = xlen_t'(op1_s >>> shamt_imm);
            OP_SLTI:  result_o = xlen_t'(op1_s < imm_s);
            // sltiu compares against the sign extended imm as unsigned
            OP_SLTIU: result_o = xlen_t'(op_if.operand1 < op_if.imm);
            // effective address for the memory stage
            OP_LOAD:  result_o = addr_sum;
            OP_STORE: result_o = addr_sum;
            // jumps write the return address
            OP_JAL:   result_o = link;
            OP_JALR:  result_o = link;
            OP_LUI:   result_o = op_if.imm;
            OP_AUIPC: result_o = pc_rel;
            // branches and none produce no result
            default:  result_o = '0;
        endcase
    end

endmodule

// File: rtl/branch_unit.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module branch_unit (
    exec_op_if.consumer     op_if,
    output exec_pkg::xlen_t target_o,
    output logic            taken_o,
    output logic            jump_o
);
    import exec_pkg::*;

    // comparator outputs, one each for eq, signed lt and unsigned lt
    logic  eq;
    logic  lt_s;
    logic  lt_u;
    xlen_t jalr_sum;

    assign eq   = (op_if.operand1 == op_if.operand2);
    assign lt_s = ($signed(op_if.operand1) < $signed(op_if.operand2));
    assign lt_u = (op_if.operand1 < op_if.operand2);

    assign jalr_sum = op_if.operand1 + op_if.imm;

    always_comb begin
        target_o = '0;
        taken_o  = 1'b0;
        jump_o   = 1'b0;
        // all branches share the pc relative target
        if (is_branch_op(op_if.op)) begin
            target_o = op_if.pc + op_if.imm;
        end
        unique case (op_if.op)
            OP_BEQ:  taken_o = eq;
            OP_BNE:  taken_o = !eq;
            OP_BLT:  taken_o = lt_s;
            OP_BGE:  taken_o = !lt_s;
            OP_BLTU: taken_o = lt_u;
            OP_BGEU: taken_o = !lt_u;
            OP_JAL: begin
                target_o = op_if.pc + op_if.imm;
                jump_o   = 1'b1;
            end
            OP_JALR: begin
                // jalr drops bit 0 of the computed address
                target_o = {jalr_sum[`XLEN-1:1], 1'b0};
                jump_o   = 1'b1;
            end
            default: begin
                jump_o = 1'b0;
            end
        endcase
    end

    // jal relies on decode handing over an even j-immediate and an aligned pc
    always_comb begin
        if (jump_o) begin
            assert final (!target_o[0])
                else $error("odd jump target %h", target_o);
        end
    end

endmodule

// File: rtl/exec_op_if.sv
`timescale 1ns/1ps

// issued operation and its operands, shared by both datapath units
interface exec_op_if;
    import exec_pkg::*;

    exec_op_e op;
    // rs1 and rs2 values from register read
    xlen_t    operand1;
    xlen_t    operand2;
    // immediate already sign extended and placed by decode
    xlen_t    imm;
    xlen_t    pc;

    // units only look at the operation, nothing flows back
    modport consumer (
        input op,
        input operand1,
        input operand2,
        input imm,
        input pc
    );

endinterface

// File: rtl/exec_pkg.sv
`include "exec_params.svh"

package exec_pkg;

    typedef logic [`XLEN-1:0]       xlen_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // encoded operation from decode
    // loads and stores are single ops since execute only forms the address
    typedef enum logic [`OP_W-1:0] {
        OP_NONE  = 5'd0,
        OP_ADD   = 5'd1,
        OP_SUB   = 5'd2,
        OP_XOR   = 5'd3,
        OP_OR    = 5'd4,
        OP_AND   = 5'd5,
        OP_SLL   = 5'd6,
        OP_SRL   = 5'd7,
        OP_SRA   = 5'd8,
        OP_SLT   = 5'd9,
        OP_SLTU  = 5'd10,
        OP_ADDI  = 5'd11,
        OP_XORI  = 5'd12,
        OP_ORI   = 5'd13,
        OP_ANDI  = 5'd14,
        OP_SLLI  = 5'd15,
        OP_SRLI  = 5'd16,
        OP_SRAI  = 5'd17,
        OP_SLTI  = 5'd18,
        OP_SLTIU = 5'd19,
        OP_LOAD  = 5'd20,
        OP_STORE = 5'd21,
        OP_BEQ   = 5'd22,
        OP_BNE   = 5'd23,
        OP_BLT   = 5'd24,
        OP_BGE   = 5'd25,
        OP_BLTU  = 5'd26,
        OP_BGEU  = 5'd27,
        OP_JAL   = 5'd28,
        OP_JALR  = 5'd29,
        OP_LUI   = 5'd30,
        OP_AUIPC = 5'd31
    } exec_op_e;

    // conditional branches sit in one contiguous code range
    function automatic logic is_branch_op(exec_op_e op);
        return (op >= OP_BEQ) && (op <= OP_BGEU);
    endfunction

    // alu ops and load write rd, store and branches do not
    function automatic logic writes_rd_op(exec_op_e op);
        return ((op >= OP_ADD) && (op <= OP_LOAD)) ||
               (op inside {OP_JAL, OP_JALR, OP_LUI, OP_AUIPC});
    endfunction

endpackage

// File: rtl/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic                i_clk,
    input  logic                reset_i,
    // issue side, one strobe per instruction
    input  logic                valid_i,
    input  exec_pkg::exec_op_e  op_i,
    input  exec_pkg::reg_addr_t rd_i,
    input  exec_pkg::xlen_t     operand1_i,
    input  exec_pkg::xlen_t     operand2_i,
    input  exec_pkg::xlen_t     imm_i,
    input  exec_pkg::xlen_t     pc_i,
    // result side, one cycle after issue
    output logic                valid_o,
    output exec_pkg::reg_addr_t rd_o,
    output exec_pkg::xlen_t     result_o,
    output exec_pkg::xlen_t     target_o,
    output logic                reg_write_o,
    output logic                branch_taken_o,
    output logic                jump_o
);
    import exec_pkg::*;

    // combinational unit outputs into the output register
    xlen_t alu_result;
    xlen_t br_target;
    logic  br_taken;
    logic  br_jump;

    exec_op_if op_if ();

    assign op_if.op       = op_i;
    assign op_if.operand1 = operand1_i;
    assign op_if.operand2 = operand2_i;
    assign op_if.imm      = imm_i;
    assign op_if.pc       = pc_i;

    alu_unit i_alu_unit (
        .op_if    (op_if),
        .result_o (alu_result)
    );

    branch_unit i_branch_unit (
        .op_if    (op_if),
        .target_o (br_target),
        .taken_o  (br_taken),
        .jump_o   (br_jump)
    );

    // single register stage gives the one cycle latency
    writeback_ctrl i_writeback_ctrl (
        .i_clk          (i_clk),
        .reset_i        (reset_i),
        .valid_i        (valid_i),
        .op_i           (op_i),
        .rd_i           (rd_i),
        .result_i       (alu_result),
        .target_i       (br_target),
        .taken_i        (br_taken),
        .jump_i         (br_jump),
        .valid_o        (valid_o),
        .rd_o           (rd_o),
        .result_o       (result_o),
        .target_o       (target_o),
        .reg_write_o    (reg_write_o),
        .branch_taken_o (branch_taken_o),
        .jump_o         (jump_o)
    );

endmodule

// File: rtl/writeback_ctrl.sv
`timescale 1ns/1ps

module writeback_ctrl (
    input  logic                i_clk,
    input  logic                reset_i,
    input  logic                valid_i,
    input  exec_pkg::exec_op_e  op_i,
    input  exec_pkg::reg_addr_t rd_i,
    input  exec_pkg::xlen_t     result_i,
    input  exec_pkg::xlen_t     target_i,
    input  logic                taken_i,
    input  logic                jump_i,
    output logic                valid_o,
    output exec_pkg::reg_addr_t rd_o,
    output exec_pkg::xlen_t     result_o,
    output exec_pkg::xlen_t     target_o,
    output logic                reg_write_o,
    output logic                branch_taken_o,
    output logic                jump_o
);
    import exec_pkg::*;

    // register write needs a writing op and a real destination
    // x0 is hardwired so a write to it is dropped here
    logic rd_write;

    assign rd_write = writes_rd_op(op_i) && (rd_i != '0);

    // payload only moves on an issued instruction, otherwise holds
    always_ff @(posedge i_clk) begin
        if (valid_i) begin
            rd_o     <= rd_i;
            result_o <= result_i;
            target_o <= target_i;
        end
    end

    // flags are strobes, cleared in every idle cycle
    always_ff @(posedge i_clk) begin
        if (reset_i) begin
            valid_o        <= 1'b0;
            reg_write_o    <= 1'b0;
            branch_taken_o <= 1'b0;
            jump_o         <= 1'b0;
        end else begin
            valid_o        <= valid_i;
            reg_write_o    <= valid_i && rd_write;
            branch_taken_o <= valid_i && taken_i;
            jump_o         <= valid_i && jump_i;
        end
    end

    // branch unit never reports a taken branch and a jump together
    a_taken_jump_excl: assert property (
        @(posedge i_clk) disable iff (reset_i)
        !(branch_taken_o && jump_o)
    ) else $error("branch taken and jump both set");

    // a taken conditional branch never writes rd
    a_taken_no_write: assert property (
        @(posedge i_clk) disable iff (reset_i)
        branch_taken_o |-> !reg_write_o
    ) else $error("taken branch also writes a register");

endmodule

// File: sim/exec_input.txt
// columns: op rd operand1 operand2 imm pc result target reg_write taken jump, all hex
// first word is the number of vectors that follow
0000001d
01 01 00000005 00000007 00000000 00001000 0000000c 00000000 1 0 0
02 02 00000005 00000007 00000000 00001000 fffffffe 00000000 1 0 0
03 03 f0f0f0f0 ff00ff00 00000000 00001000 0ff00ff0 00000000 1 0 0
05 05 f0f0f0f0 ff00ff00 00000000 00001000 f000f000 00000000 1 0 0
06 06 00000003 00000024 00000000 00001000 00000030 00000000 1 0 0
07 07 80000000 00000021 00000000 00001000 40000000 00000000 1 0 0
08 08 80000000 00000004 00000000 00001000 f8000000 00000000 1 0 0
09 09 ffffffff 00000001 00000000 00001000 00000001 00000000 1 0 0
0a 0a ffffffff 00000001 00000000 00001000 00000000 00000000 1 0 0
0b 0b 00000010 00000000 fffffffc 00001000 0000000c 00000000 1 0 0
0c 0c 0000ffff 00000000 ffffffff 00001000 ffff0000 00000000 1 0 0
0f 0f 00000001 00000000 0000003f 00001000 80000000 00000000 1 0 0
11 11 f0000000 00000000 00000404 00001000 ff000000 00000000 1 0 0
12 12 fffffffe 00000000 ffffffff 00001000 00000001 00000000 1 0 0
13 13 00000005 00000000 ffffffff 00001000 00000001 00000000 1 0 0
14 14 00002000 00000000 00000010 00001000 00002010 00000000 1 0 0
15 15 00002000 00000000 fffffff8 00001000 00001ff8 00000000 0 0 0
14 00 00000100 00000000 00000004 00001000 00000104 00000000 0 0 0
16 1f 00000007 00000007 00000010 00001000 00000000 00001010 0 1 0
17 1f 00000007 00000007 00000020 00001004 00000000 00001024 0 0 0
18 1f ffffffff 00000001 fffffff0 00001008 00000000 00000ff8 0 1 0
19 1f ffffffff 00000001 00000008 0000100c 00000000 00001014 0 0 0
1a 1f ffffffff 00000001 0000000c 00001010 00000000 0000101c 0 0 0
1b 1f ffffffff 00000001 00000100 00001014 00000000 00001114 0 1 0
1c 01 00000000 00000000 00000800 00001018 0000101c 00001818 1 0 1
1d 05 00003001 00000000 00000004 0000101c 00001020 00003004 1 0 1
1e 06 00000000 00000000 12345000 00001020 12345000 00000000 1 0 0
1f 07 00000000 00000000 00010000 00001024 00011024 00000000 1 0 0
00 08 00000001 00000002 00000003 00001028 00000000 00000000 0 0 0

// File: sim/tb_exec_stage.sv
`timescale 1ns/1ps

module tb_exec_stage;
    import exec_pkg::*;

    // each vector is 11 words after the leading count word
    localparam int FIELDS    = 11;
    localparam int MAX_VEC   = 64;
    localparam int EXTRA_VEC = 5;

    logic      i_clk;
    logic      reset_i;
    logic      valid_i;
    exec_op_e  op_i;
    reg_addr_t rd_i;
    xlen_t     operand1_i;
    xlen_t     operand2_i;
    xlen_t     imm_i;
    xlen_t     pc_i;
    logic      valid_o;
    reg_addr_t rd_o;
    xlen_t     result_o;
    xlen_t     target_o;
    logic      reg_write_o;
    logic      branch_taken_o;
    logic      jump_o;

    logic [31:0] vec_mem [0:FIELDS*MAX_VEC];
    int          vec_cnt;
    // vectors in flight and the cycle each result is due
    int          vec_q[$];
    int          due_q[$];
    int          cycle_cnt;
    int          mismatch_cnt;
    int          timeout_cnt;
    int          other_cnt;
    integer      seed;

    exec_stage i_exec_stage (
        .i_clk          (i_clk),
        .reset_i        (reset_i),
        .valid_i        (valid_i),
        .op_i           (op_i),
        .rd_i           (rd_i),
        .operand1_i     (operand1_i),
        .operand2_i     (operand2_i),
        .imm_i          (imm_i),
        .pc_i           (pc_i),
        .valid_o        (valid_o),
        .rd_o           (rd_o),
        .result_o       (result_o),
        .target_o       (target_o),
        .reg_write_o    (reg_write_o),
        .branch_taken_o (branch_taken_o),
        .jump_o         (jump_o)
    );

    // 4 ns period
    always #2 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        if (reset_i) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input int vec);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: vector %0d %s got %h expected %h",
                     $time, vec, name, got, exp);
        end
    endtask

    // compare every output against the expected words of one vector
    task automatic check_result(input int vec, input int due);
        int b;
        b = 1 + vec * FIELDS;
        if (cycle_cnt != due) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: vector %0d came in cycle %0d, due in cycle %0d",
                     $time, vec, cycle_cnt, due);
        end
        check_field("rd", {27'b0, rd_o}, vec_mem[b+1], vec);
        check_field("result", result_o, vec_mem[b+6], vec);
        check_field("target", target_o, vec_mem[b+7], vec);
        check_field("reg_write", {31'b0, reg_write_o}, vec_mem[b+8], vec);
        check_field("taken", {31'b0, branch_taken_o}, vec_mem[b+9], vec);
        check_field("jump", {31'b0, jump_o}, vec_mem[b+10], vec);
    endtask

    // append one vector behind the ones read from the file
    task automatic add_vector(input exec_op_e op, input reg_addr_t rd,
                              input xlen_t op1, input xlen_t op2,
                              input xlen_t imm, input xlen_t pc,
                              input xlen_t res, input xlen_t tgt,
                              input logic wr, input logic tk, input logic jp);
        int b;
        b = 1 + vec_cnt * FIELDS;
        vec_mem[b]    = {27'b0, op};
        vec_mem[b+1]  = {27'b0, rd};
        vec_mem[b+2]  = op1;
        vec_mem[b+3]  = op2;
        vec_mem[b+4]  = imm;
        vec_mem[b+5]  = pc;
        vec_mem[b+6]  = res;
        vec_mem[b+7]  = tgt;
        vec_mem[b+8]  = {31'b0, wr};
        vec_mem[b+9]  = {31'b0, tk};
        vec_mem[b+10] = {31'b0, jp};
        vec_cnt++;
    endtask

    // drive one vector with a valid strobe and queue its expectation
    task automatic apply_vector(input int vec);
        int b;
        b = 1 + vec * FIELDS;
        valid_i    = 1'b1;
        op_i       = exec_op_e'(vec_mem[b][4:0]);
        rd_i       = vec_mem[b+1][4:0];
        operand1_i = vec_mem[b+2];
        operand2_i = vec_mem[b+3];
        imm_i      = vec_mem[b+4];
        pc_i       = vec_mem[b+5];
        vec_q.push_back(vec);
        due_q.push_back(cycle_cnt + 1);
    endtask

    // outputs are sampled mid-cycle, away from the rising edge
    always @(negedge i_clk) begin
        if (!reset_i) begin
            if (valid_o === 1'b1) begin
                if (vec_q.size() == 0) begin
                    other_cnt++;
                    $display("valid_o went high at %0t with no instruction in flight", $time);
                end else begin
                    check_result(vec_q.pop_front(), due_q.pop_front());
                end
            end else begin
                if (valid_o !== 1'b0 || reg_write_o !== 1'b0 ||
                    branch_taken_o !== 1'b0 || jump_o !== 1'b0) begin
                    mismatch_cnt++;
                    $display("Mismatch at %0t: valid_o or a flag not low in an idle cycle",
                             $time);
                end
                // result overdue, drop it so later vectors stay aligned
                if (due_q.size() != 0 && cycle_cnt >= due_q[0]) begin
                    timeout_cnt++;
                    $display("valid_o never came for vector %0d by %0t", vec_q[0], $time);
                    void'(vec_q.pop_front());
                    void'(due_q.pop_front());
                end
            end
        end
    end

    initial begin
        int          i;
        int          gap;
        int          wait_cnt;
        logic [31:0] rnd;
        seed         = 32'h9e3d;
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        other_cnt    = 0;
        i_clk        = 1'b0;
        reset_i      = 1'b1;
        valid_i      = 1'b0;
        op_i         = OP_NONE;
        rd_i         = '0;
        operand1_i   = '0;
        operand2_i   = '0;
        imm_i        = '0;
        pc_i         = '0;
        $readmemh("sim/exec_input.txt", vec_mem);
        vec_cnt = int'(vec_mem[0]);
        if (vec_cnt < 1 || vec_cnt > MAX_VEC - EXTRA_VEC) begin
            other_cnt++;
            $display("vector file holds a bad vector count: %0d", vec_cnt);
            vec_cnt = 0;
        end
        // or forms, andi, srli and a slti that unsigned compare gets wrong
        add_vector(OP_OR, 5'd4, 32'hf0f0f0f0, 32'hff00ff00, 32'h0, 32'h1000,
                   32'hfff0fff0, 32'h0, 1'b1, 1'b0, 1'b0);
        add_vector(OP_ORI, 5'd13, 32'h0f0f0000, 32'h0, 32'h000000f0, 32'h1000,
                   32'h0f0f00f0, 32'h0, 1'b1, 1'b0, 1'b0);
        add_vector(OP_ANDI, 5'd14, 32'h12345678, 32'h0, 32'h00000ff0, 32'h1000,
                   32'h00000670, 32'h0, 1'b1, 1'b0, 1'b0);
        add_vector(OP_SRLI, 5'd16, 32'h80000000, 32'h0, 32'h00000023, 32'h1000,
                   32'h10000000, 32'h0, 1'b1, 1'b0, 1'b0);
        add_vector(OP_SLTI, 5'd18, 32'hfffffffe, 32'h80000000, 32'h00000001, 32'h1000,
                   32'h00000001, 32'h0, 1'b1, 1'b0, 1'b0);
        repeat (4) @(posedge i_clk);
        #1;
        reset_i = 1'b0;
        @(posedge i_clk);
        #1;
        for (i = 0; i < vec_cnt; i++) begin
            apply_vector(i);
            @(posedge i_clk);
            #1;
            valid_i = 1'b0;
            // half the time back to back, else 0 to 3 idle cycles
            rnd = $random(seed);
            gap = rnd[2] ? 0 : int'(rnd[1:0]);
            repeat (gap) begin
                @(posedge i_clk);
                #1;
            end
        end
        wait_cnt = 0;
        while (vec_q.size() != 0 && wait_cnt < 8) begin
            @(posedge i_clk);
            wait_cnt++;
        end
        if (vec_q.size() != 0) begin
            timeout_cnt++;
            $display("timed out waiting for the last results to come out");
        end
        @(negedge i_clk);
        #1;
        $display("errors: %0d mismatch, %0d timeout, %0d other",
                 mismatch_cnt, timeout_cnt, other_cnt);
        if (mismatch_cnt + timeout_cnt + other_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
rtl/exec_pkg.sv
rtl/exec_op_if.sv
rtl/alu_unit.sv
rtl/branch_unit.sv
rtl/writeback_ctrl.sv
rtl/exec_stage.sv
sim/tb_exec_stage.sv
